/* bench/hdc_item_memory_sva.sv */
`timescale 1ns/1ps

module hdc_item_memory_sva
    import hdc_pkg::*;
(
    input logic AXIS_ACLK,
    input logic S_AXI_ARESETN,
    input logic s_axi_bvalid,
    input logic s_axi_bready,
    input logic s_axi_rvalid,
    input logic s_axi_rready,
    input logic m_axis_tvalid,
    input hv_t  m_axis_tdata,
    input logic m_axis_tlast,
    input logic m_axis_tready
);

    // read by the testbench at the end of the run
    int error_count = 0;

    // ====================
    // AXI-Lite responses
    // ====================

    bvalid_hold: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else begin
            error_count++;
            $error("bvalid dropped before bready");
        end

    rvalid_hold: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
        else begin
            error_count++;
            $error("rvalid dropped before rready");
        end

    // ====================
    // AXI-Stream beat
    // ====================

    tvalid_stall: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata))
        else begin
            error_count++;
            $error("tvalid or tdata changed while the beat was stalled");
        end

    tlast_match: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        m_axis_tlast == m_axis_tvalid)
        else begin
            error_count++;
            $error("tlast differs from tvalid");
        end

    // synchronous reset, so tvalid is low from the cycle after
    tvalid_reset: assert property (@(posedge AXIS_ACLK)
        !S_AXI_ARESETN |=> !m_axis_tvalid)
        else begin
            error_count++;
            $error("tvalid high during reset");
        end

endmodule

bind hdc_item_memory hdc_item_memory_sva sva_i (
    .AXIS_ACLK     (AXIS_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready)
);

/* bench/hdc_item_memory_tb.sv */
`timescale 1ns/1ps
`include "hdc_defines.svh"

module hdc_item_memory_tb
    import hdc_pkg::*;
();

    // cycles allowed for any single wait
    localparam int LIMIT = 500;

    logic        AXIS_ACLK;
    logic        S_AXI_ARESETN;
    logic [31:0] s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [31:0] s_axi_araddr;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;
    logic        m_axis_tvalid;
    hv_t         m_axis_tdata;
    logic        m_axis_tlast;
    logic        m_axis_tready;

    hdc_item_memory hdc_item_memory_i (.*);

    always #50 AXIS_ACLK = !AXIS_ACLK;

    // ====================
    // helpers
    // ====================

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic next_edge(inout int n, input string what);
        @(negedge AXIS_ACLK);
        n++;
        if (n > LIMIT) begin
            stop_on_timeout(what);
        end
    endtask

    task automatic check_eq(input string name, input hv_t got, input hv_t exp);
        assert (got === exp) else begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // expected item from the xorshift32 rule, seed first
    function automatic hv_t model_item(input int idx);
        logic [31:0] s;
        hv_t         v;
        s = `HDC_XS_SEED;
        v = '0;
        for (int j = 0; j < (idx + 1) * `HDC_WORDS; j++) begin
            s = s ^ (s << 13);
            s = s ^ (s >> 17);
            s = s ^ (s << 5);
            v[(j % `HDC_WORDS) * `HDC_WORD_W +: `HDC_WORD_W] = s;
        end
        return v;
    endfunction

    // ====================
    // AXI-Lite master
    // ====================

    // order 0 both together, 1 address first, 2 data first
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data, input int order);
        int n;
        n = 0;
        @(negedge AXIS_ACLK);
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = (order != 2);
        s_axi_wvalid  = (order != 1);
        while (!((s_axi_awready || !s_axi_awvalid) && (s_axi_wready || !s_axi_wvalid))) begin
            next_edge(n, "write channel ready");
        end
        next_edge(n, "write handshake");
        // second channel of a split write
        s_axi_awvalid = (order == 2);
        s_axi_wvalid  = (order == 1);
        while (!((s_axi_awready || !s_axi_awvalid) && (s_axi_wready || !s_axi_wvalid))) begin
            next_edge(n, "write channel ready");
        end
        if (order != 0) begin
            next_edge(n, "write handshake");
            s_axi_awvalid = 1'b0;
            s_axi_wvalid  = 1'b0;
        end
        while (!s_axi_bvalid) begin
            next_edge(n, "bvalid");
        end
        check_eq("s_axi_bresp", s_axi_bresp, 2'b00);
        repeat ($urandom_range(2)) next_edge(n, "bready stall");
        s_axi_bready = 1'b1;
        next_edge(n, "write response");
        s_axi_bready = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        int n;
        n = 0;
        @(negedge AXIS_ACLK);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        while (!s_axi_arready) begin
            next_edge(n, "arready");
        end
        next_edge(n, "read address handshake");
        s_axi_arvalid = 1'b0;
        while (!s_axi_rvalid) begin
            next_edge(n, "rvalid");
        end
        repeat ($urandom_range(2)) next_edge(n, "rready stall");
        data = s_axi_rdata;
        check_eq("s_axi_rresp", s_axi_rresp, 2'b00);
        s_axi_rready = 1'b1;
        next_edge(n, "read data");
        s_axi_rready = 1'b0;
    endtask

    task automatic check_reg(input logic [31:0] addr, input logic [31:0] exp, input string name);
        logic [31:0] got;
        bus_read(addr, got);
        check_eq(name, got, exp);
    endtask

    task automatic wait_gen_clear();
        logic [31:0] ctrl;
        int          polls;
        polls = 0;
        bus_read(`HDC_REG_CTRL, ctrl);
        while (ctrl[0]) begin
            polls++;
            if (polls > LIMIT) begin
                stop_on_timeout("gen to clear");
            end
            bus_read(`HDC_REG_CTRL, ctrl);
        end
    endtask

    // ====================
    // stream sink
    // ====================

    task automatic take_beat(input hv_t exp, input bit stall);
        int n;
        n = 0;
        while (!(m_axis_tvalid && m_axis_tready)) begin
            next_edge(n, "stream beat");
            m_axis_tready = stall ? ($urandom_range(3) == 0) : 1'b1;
        end
        check_eq("m_axis_tdata", m_axis_tdata, exp);
        check_eq("m_axis_tlast", m_axis_tlast, 1'b1);
        next_edge(n, "stream handshake");
        m_axis_tready = 1'b0;
    endtask

    task automatic gen_and_send(input int idx, input bit stall);
        bus_write(`HDC_REG_ITEM, idx, 0);
        bus_write(`HDC_REG_CTRL, 32'h1, 0);
        wait_gen_clear();
        bus_write(`HDC_REG_CTRL, 32'h2, 0);
        take_beat(model_item(idx), stall);
        check_reg(`HDC_REG_CTRL, 32'h0, "ctrl");
    endtask

    // a pending beat must never see gen set
    always @(negedge AXIS_ACLK) begin
        if (S_AXI_ARESETN === 1'b1) begin
            assert (!(m_axis_tvalid && hdc_item_memory_i.cfg.gen)) else begin
                $display("stream beat pending while gen is set");
                $display("CHECKS FAILED");
                $fatal(1, "overlap check failed");
            end
        end
    end

    // stop at the first bound assertion failure
    always @(negedge AXIS_ACLK) begin
        if (hdc_item_memory_i.sva_i.error_count != 0) begin
            $display("a bound assertion on the DUT ports failed");
            $display("CHECKS FAILED");
            $fatal(1, "bound assertions failed");
        end
    end

    // ====================
    // stimulus
    // ====================

    initial begin
        int idx;
        void'($urandom(99));
        AXIS_ACLK     = 1'b0;
        S_AXI_ARESETN = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        m_axis_tready = 1'b0;
        repeat (3) @(negedge AXIS_ACLK);
        S_AXI_ARESETN = 1'b1;

        // reset values, readback, unmapped address
        check_reg(`HDC_REG_CTRL, 32'h0, "ctrl");
        check_reg(`HDC_REG_ITEM, 32'h0, "item_select");
        bus_write(`HDC_REG_ITEM, 32'h0000_A5C3, 0);
        check_reg(`HDC_REG_ITEM, 32'h0000_A5C3, "item_select");
        check_reg(32'h0000_0008, 32'h0, "unmapped");

        // split writes in both orders
        bus_write(`HDC_REG_ITEM, 32'h0000_1234, 1);
        check_reg(`HDC_REG_ITEM, 32'h0000_1234, "item_select");
        bus_write(`HDC_REG_ITEM, 32'h0000_0000, 2);
        check_reg(`HDC_REG_ITEM, 32'h0000_0000, "item_select");

        // item 0 without back-pressure
        gen_and_send(0, 1'b0);

        // random items under back-pressure
        repeat (3) begin
            idx = $urandom_range(5);
            gen_and_send(idx, 1'b1);
        end

        // run and gen together, beat must carry the new item
        idx = (idx + 3) % 6;
        bus_write(`HDC_REG_ITEM, idx, 0);
        bus_write(`HDC_REG_CTRL, 32'h3, 0);
        take_beat(model_item(idx), 1'b1);
        check_reg(`HDC_REG_CTRL, 32'h0, "ctrl");

        repeat (4) @(negedge AXIS_ACLK);
        if (hdc_item_memory_i.sva_i.error_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("%0d bound assertion failures", hdc_item_memory_i.sva_i.error_count);
            $display("CHECKS FAILED");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

/* hdc_item_memory.f */
+incdir+src
src/hdc_pkg.sv
src/xorshift32.sv
src/hv_assembler.sv
src/hv_stream_out.sv
src/item_gen_ctrl.sv
src/axi_lite_regs.sv
src/hdc_item_memory.sv
bench/hdc_item_memory_sva.sv
bench/hdc_item_memory_tb.sv

/* src/axi_lite_regs.sv */
`timescale 1ns/1ps
`include "hdc_defines.svh"
`default_nettype none

module axi_lite_regs
    import hdc_pkg::*;
(
    input  wire logic        AXIS_ACLK,
    input  wire logic        S_AXI_ARESETN,
    input  wire logic [31:0] s_axi_awaddr,
    input  wire logic        s_axi_awvalid,
    output logic             s_axi_awready,
    input  wire logic [31:0] s_axi_wdata,
    input  wire logic        s_axi_wvalid,
    output logic             s_axi_wready,
    output logic [1:0]       s_axi_bresp,
    output logic             s_axi_bvalid,
    input  wire logic        s_axi_bready,
    input  wire logic [31:0] s_axi_araddr,
    input  wire logic        s_axi_arvalid,
    output logic             s_axi_arready,
    output logic [31:0]      s_axi_rdata,
    output logic [1:0]       s_axi_rresp,
    output logic             s_axi_rvalid,
    input  wire logic        s_axi_rready,
    output ctrl_cfg_t        cfg,
    input  wire ctrl_evt_t   evt
);

    axil_state_e state;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [31:0] rd_addr;
    // one-cycle strobe, first cycle of write_resp
    logic        wr_en;

    // ====================
    // handshake outputs
    // ====================

    assign s_axi_awready = (state == idle) || (state == got_w);
    assign s_axi_wready  = (state == idle) || (state == got_aw);
    // writes win in idle, so ar is only taken with no write pending
    assign s_axi_arready = (state == idle) && !s_axi_awvalid && !s_axi_wvalid;
    assign s_axi_bvalid  = (state == write_resp);
    assign s_axi_rvalid  = (state == read_data);
    assign s_axi_bresp   = 2'b00;
    assign s_axi_rresp   = 2'b00;

    // ====================
    // slave FSM
    // ====================

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= idle;
            wr_en <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            case (state)
                idle: begin
                    if (s_axi_awvalid && s_axi_wvalid) begin
                        wr_addr <= s_axi_awaddr;
                        wr_data <= s_axi_wdata;
                        wr_en   <= 1'b1;
                        state   <= write_resp;
                    end else if (s_axi_awvalid) begin
                        wr_addr <= s_axi_awaddr;
                        state   <= got_aw;
                    end else if (s_axi_wvalid) begin
                        wr_data <= s_axi_wdata;
                        state   <= got_w;
                    end else if (s_axi_arvalid) begin
                        rd_addr <= s_axi_araddr;
                        state   <= read_addr;
                    end
                end
                got_aw: begin
                    if (s_axi_wvalid) begin
                        wr_data <= s_axi_wdata;
                        wr_en   <= 1'b1;
                        state   <= write_resp;
                    end
                end
                got_w: begin
                    if (s_axi_awvalid) begin
                        wr_addr <= s_axi_awaddr;
                        wr_en   <= 1'b1;
                        state   <= write_resp;
                    end
                end
                write_resp: begin
                    if (s_axi_bready) begin
                        state <= idle;
                    end
                end
                // rdata is loaded here, rvalid follows next cycle
                read_addr: begin
                    state <= read_data;
                end
                read_data: begin
                    if (s_axi_rready) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // ====================
    // register file
    // ====================

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            cfg <= '0;
        end else begin
            // self-clearing bits
            if (evt.gen_done) begin
                cfg.gen <= 1'b0;
            end
            if (evt.run_done) begin
                cfg.run <= 1'b0;
            end
            // a software write in the same cycle takes precedence
            if (wr_en && wr_addr == `HDC_REG_CTRL) begin
                cfg.run <= wr_data[1];
                cfg.gen <= wr_data[0];
            end
            if (wr_en && wr_addr == `HDC_REG_ITEM) begin
                cfg.item_select <= wr_data[`HDC_ITEM_W-1:0];
            end
        end
    end

    // read mux, unmapped addresses read as zero
    always_ff @(posedge AXIS_ACLK) begin
        if (state == read_addr) begin
            case (rd_addr)
                `HDC_REG_CTRL: s_axi_rdata <= {30'd0, cfg.run, cfg.gen};
                `HDC_REG_ITEM: s_axi_rdata <= 32'(cfg.item_select);
                default:       s_axi_rdata <= 32'd0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/hdc_defines.svh */
`ifndef HDC_DEFINES_SVH
`define HDC_DEFINES_SVH

// ====================
// datapath widths
// ====================
`define HDC_WORD_W  32
`define HDC_HV_W    1024
`define HDC_WORDS   32
`define HDC_WIDX_W  5
`define HDC_ITEM_W  16

// xorshift32 start state, also the idle state
`define HDC_XS_SEED 32'h92D68CA2

// ====================
// AXI-Lite register map
// ====================
`define HDC_REG_CTRL 32'h0000_0000
`define HDC_REG_ITEM 32'h0000_0004

`endif

/* src/hdc_item_memory.sv */
`timescale 1ns/1ps
`include "hdc_defines.svh"
`default_nettype none

module hdc_item_memory
    import hdc_pkg::*;
(
    input  wire logic        AXIS_ACLK,
    input  wire logic        S_AXI_ARESETN,
    // AXI-Lite slave
    input  wire logic [31:0] s_axi_awaddr,
    input  wire logic        s_axi_awvalid,
    output logic             s_axi_awready,
    input  wire logic [31:0] s_axi_wdata,
    input  wire logic        s_axi_wvalid,
    output logic             s_axi_wready,
    output logic [1:0]       s_axi_bresp,
    output logic             s_axi_bvalid,
    input  wire logic        s_axi_bready,
    input  wire logic [31:0] s_axi_araddr,
    input  wire logic        s_axi_arvalid,
    output logic             s_axi_arready,
    output logic [31:0]      s_axi_rdata,
    output logic [1:0]       s_axi_rresp,
    output logic             s_axi_rvalid,
    input  wire logic        s_axi_rready,
    // AXI-Stream master
    output logic             m_axis_tvalid,
    output hv_t              m_axis_tdata,
    output logic             m_axis_tlast,
    input  wire logic        m_axis_tready
);

    ctrl_cfg_t               cfg;
    ctrl_evt_t               evt;
    logic                    gen_active;
    logic [`HDC_WIDX_W-1:0]  word_idx;
    logic                    capture;
    logic                    launch;
    logic                    beat_done;
    word_t                   rand_word;
    hv_t                     item_hv;

    // ====================
    // control path
    // ====================

    axi_lite_regs axi_lite_regs_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .cfg           (cfg),
        .evt           (evt)
    );

    item_gen_ctrl item_gen_ctrl_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .cfg           (cfg),
        .evt           (evt),
        .gen_active    (gen_active),
        .word_idx      (word_idx),
        .capture       (capture),
        .launch        (launch),
        .beat_done     (beat_done)
    );

    // ====================
    // datapath
    // ====================

    xorshift32 xorshift32_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen_active    (gen_active),
        .rand_word     (rand_word)
    );

    hv_assembler hv_assembler_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen_active    (gen_active),
        .word_idx      (word_idx),
        .rand_word     (rand_word),
        .capture       (capture),
        .item_hv       (item_hv)
    );

    hv_stream_out hv_stream_out_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .launch        (launch),
        .item_hv       (item_hv),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tready (m_axis_tready),
        .beat_done     (beat_done)
    );

endmodule

`default_nettype wire

/* src/hdc_pkg.sv */
`include "hdc_defines.svh"

package hdc_pkg;

    // ====================
    // payload types
    // ====================

    // one full item hypervector
    typedef logic [`HDC_HV_W-1:0] hv_t;

    // one generator output word
    typedef logic [`HDC_WORD_W-1:0] word_t;

    // item number inside the item memory
    typedef logic [`HDC_ITEM_W-1:0] item_idx_t;

    // ====================
    // control handoff
    // ====================

    // software view of the control and item-select registers
    typedef struct packed {
        logic      run;
        logic      gen;
        item_idx_t item_select;
    } ctrl_cfg_t;

    // single-cycle pulses back to the register block
    typedef struct packed {
        logic gen_done;
        logic run_done;
    } ctrl_evt_t;

    // AXI-Lite slave FSM
    typedef enum logic [2:0] {
        idle,
        got_aw,
        got_w,
        write_resp,
        read_addr,
        read_data
    } axil_state_e;

endpackage

/* src/hv_assembler.sv */
`timescale 1ns/1ps
`include "hdc_defines.svh"
`default_nettype none

module hv_assembler
    import hdc_pkg::*;
(
    input  wire logic                   AXIS_ACLK,
    input  wire logic                   S_AXI_ARESETN,
    input  wire logic                   gen_active,
    input  wire logic [`HDC_WIDX_W-1:0] word_idx,
    input  wire word_t                  rand_word,
    input  wire logic                   capture,
    output hv_t                         item_hv
);

    // vector under construction
    hv_t work;
    // work with this cycle's word already dropped in
    hv_t work_next;

    always_comb begin
        work_next = work;
        work_next[word_idx * `HDC_WORD_W +: `HDC_WORD_W] = rand_word;
    end

    // ====================
    // working vector
    // ====================

    always_ff @(posedge AXIS_ACLK) begin
        if (gen_active) begin
            work <= work_next;
        end
    end

    // ====================
    // held item
    // ====================

    // capture lands on the last word, so take work_next and not work
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            item_hv <= '0;
        end else if (capture) begin
            item_hv <= work_next;
        end
    end

endmodule

`default_nettype wire

/* src/hv_stream_out.sv */
`timescale 1ns/1ps
`include "hdc_defines.svh"
`default_nettype none

module hv_stream_out
    import hdc_pkg::*;
(
    input  wire logic AXIS_ACLK,
    input  wire logic S_AXI_ARESETN,
    input  wire logic launch,
    input  wire hv_t  item_hv,
    output logic      m_axis_tvalid,
    output hv_t       m_axis_tdata,
    output logic      m_axis_tlast,
    input  wire logic m_axis_tready,
    output logic      beat_done
);

    // only load into an empty slot
    logic load;

    assign load      = launch && !m_axis_tvalid;
    assign beat_done = m_axis_tvalid && m_axis_tready;

    // single-beat packets
    assign m_axis_tlast = m_axis_tvalid;

    // ====================
    // beat register
    // ====================

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            m_axis_tvalid <= 1'b0;
        end else if (load) begin
            m_axis_tvalid <= 1'b1;
        end else if (beat_done) begin
            m_axis_tvalid <= 1'b0;
        end
    end

    // held until the beat is accepted
    always_ff @(posedge AXIS_ACLK) begin
        if (load) begin
            m_axis_tdata <= item_hv;
        end
    end

endmodule

`default_nettype wire

/* src/item_gen_ctrl.sv */
`timescale 1ns/1ps
`include "hdc_defines.svh"
`default_nettype none

module item_gen_ctrl
    import hdc_pkg::*;
(
    input  wire logic                   AXIS_ACLK,
    input  wire logic                   S_AXI_ARESETN,
    input  wire ctrl_cfg_t              cfg,
    output ctrl_evt_t                   evt,
    output logic                        gen_active,
    output logic [`HDC_WIDX_W-1:0]      word_idx,
    output logic                        capture,
    output logic                        launch,
    input  wire logic                   beat_done
);

    localparam logic [`HDC_WIDX_W-1:0] LAST_WORD = `HDC_WIDX_W'(`HDC_WORDS - 1);

    item_idx_t item_cnt;
    logic      word_wrap;
    // a beat has been issued for the current run
    logic      launched;

    // ====================
    // generation
    // ====================

    assign gen_active = cfg.gen;
    assign word_wrap  = gen_active && (word_idx == LAST_WORD);
    // last word of the selected item is on rand_word this cycle
    assign capture    = word_wrap && (item_cnt == cfg.item_select);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen_active) begin
            word_idx <= '0;
            item_cnt <= '0;
        end else if (word_wrap) begin
            word_idx <= '0;
            item_cnt <= item_cnt + 1'b1;
        end else begin
            word_idx <= word_idx + 1'b1;
        end
    end

    // ====================
    // stream launch
    // ====================

    // never while generating, so the held item is stable
    assign launch = cfg.run && !cfg.gen && !launched;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            launched <= 1'b0;
        end else if (!cfg.run || beat_done) begin
            launched <= 1'b0;
        end else if (launch) begin
            launched <= 1'b1;
        end
    end

    always_comb begin
        evt.gen_done = capture;
        evt.run_done = beat_done;
    end

endmodule

`default_nettype wire

/* src/xorshift32.sv */
`timescale 1ns/1ps
`include "hdc_defines.svh"
`default_nettype none

module xorshift32
    import hdc_pkg::*;
(
    input  wire logic AXIS_ACLK,
    input  wire logic S_AXI_ARESETN,
    input  wire logic gen_active,
    output word_t     rand_word
);

    word_t state;
    word_t step_a;
    word_t step_b;

    // one xorshift32 step, 13 / 17 / 5
    always_comb begin
        step_a    = state ^ (state << 13);
        step_b    = step_a ^ (step_a >> 17);
        rand_word = step_b ^ (step_b << 5);
    end

    // sits on the seed whenever no item is being generated
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen_active) begin
            state <= `HDC_XS_SEED;
        end else begin
            state <= rand_word;
        end
    end

endmodule

`default_nettype wire
